// File: rtl/hacd_cfg_pkg.sv
`default_nettype none

// sizes and defaults of the memory-path core
package hacd_cfg_pkg;

   //////////////////////////////
   // datapath widths
   localparam int ADDR_W = 16;  // line address, not byte address
   localparam int LINE_W = 64;  // one cache line of data

   // line counts, wide enough for a full page or table
   localparam int CNT_W  = 8;

   //////////////////////////////
   // default sizes, top level may override

   // first line of the page table region
   localparam logic [ADDR_W-1:0] DEF_TBL_BASE = 16'h0100;
   localparam int DEF_TBL_LINES   = 8;  // lines zeroed by the sweep
   localparam int DEF_PAGE_LINES  = 8;  // lines per page

   // flow control
   localparam int DEF_MEM_CREDITS = 4;  // outstanding requests to memory
   localparam int DEF_CPU_Q_DEPTH = 4;  // per cpu channel, also its credits

endpackage

`default_nettype wire

// File: rtl/hacd_bus_pkg.sv
`default_nettype none

// request, response and state types shared by the core blocks
package hacd_bus_pkg;
   import hacd_cfg_pkg::*;

   // who owns a memory request, echoed back on the response
   typedef enum logic {
      SRC_HAWK = 1'b0,
      SRC_CPU  = 1'b1
   } src_e;

   typedef enum logic [1:0] {
      CS_INIT = 2'd0,  // table sweep
      CS_RUN  = 2'd1,  // cpu pass-through
      CS_COMP = 2'd2   // page read for compression
   } ctrl_state_e;

   //////////////////////////////
   // cpu side
   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
   } cpu_rd_req_t;

   typedef struct packed {
      logic              valid;
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] data;
   } cpu_wr_req_t;

   typedef struct packed {
      logic              valid;
      logic [LINE_W-1:0] data;
   } cpu_rd_rsp_t;

   //////////////////////////////
   // memory side
   typedef struct packed {
      logic              valid;
      logic              write;  // no response comes back for writes
      src_e              src;
      logic [ADDR_W-1:0] addr;
      logic [LINE_W-1:0] data;
   } mem_req_t;

   typedef struct packed {
      logic              valid;
      src_e              src;
      logic [LINE_W-1:0] data;
   } mem_rsp_t;

   // compressor verdict for one page
   typedef struct packed {
      logic             valid;
      logic [CNT_W-1:0] nonzero_lines;
      logic             incompressible;
   } comp_rslt_t;

endpackage

`default_nettype wire

// File: rtl/hacd_line_cntr.sv
`timescale 1ns/1ps
`default_nettype none

// walks the lines of a sweep, one per step
module hacd_line_cntr #(
   parameter int LIMIT = hacd_cfg_pkg::DEF_TBL_LINES  // longest sweep supported
) (
   input  logic                           clk_i,
   input  logic                           arst_n_i,
   input  logic                           clr_i,
   input  logic                           step_i,
   input  logic [hacd_cfg_pkg::CNT_W-1:0] len_i,
   output logic [hacd_cfg_pkg::CNT_W-1:0] idx_o,
   output logic                           last_o
);
   import hacd_cfg_pkg::*;

   logic [CNT_W-1:0] idx_q;
   logic [CNT_W-1:0] len_eff;

   // clamp to what the owner sized us for
   assign len_eff = (len_i > CNT_W'(LIMIT)) ? CNT_W'(LIMIT) : len_i;
   assign last_o  = (idx_q == len_eff - CNT_W'(1));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         idx_q <= '0;
      end else if (clr_i) begin
         idx_q <= '0;
      end else if (step_i && !last_o) begin
         idx_q <= idx_q + CNT_W'(1);  // parks on the last line
      end
   end

   assign idx_o = idx_q;

endmodule

`default_nettype wire

// File: rtl/hacd_req_queue.sv
`timescale 1ns/1ps
`default_nettype none

// circular request buffer, one credit back per pop
module hacd_req_queue #(
   parameter type payload_t = hacd_bus_pkg::cpu_rd_req_t,
   parameter int  DEPTH     = hacd_cfg_pkg::DEF_CPU_Q_DEPTH
) (
   input  logic     clk_i,
   input  logic     arst_n_i,
   input  payload_t push_i,
   input  logic     pop_i,
   output payload_t head_o,
   output logic     credit_o
);
   localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int FILL_W = $clog2(DEPTH + 1);

   payload_t          buf_q [DEPTH];
   logic [PTR_W-1:0]  wr_ptr_q, rd_ptr_q;
   logic [FILL_W-1:0] fill_q;
   logic              credit_q;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
   endfunction

   // credits upstream keep pushes within DEPTH
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         fill_q   <= '0;
         credit_q <= 1'b0;
      end else begin
         if (push_i.valid) wr_ptr_q <= ptr_inc(wr_ptr_q);
         if (pop_i) rd_ptr_q <= ptr_inc(rd_ptr_q);
         fill_q   <= fill_q + FILL_W'(push_i.valid) - FILL_W'(pop_i);
         credit_q <= pop_i;  // slot frees the cycle after the pop
      end
   end

   always_ff @(posedge clk_i) begin
      if (push_i.valid) buf_q[wr_ptr_q] <= push_i;
   end

   always_comb begin
      head_o       = buf_q[rd_ptr_q];
      head_o.valid = (fill_q != '0);  // stale entry when empty
   end

   assign credit_o = credit_q;

endmodule

`default_nettype wire

// File: rtl/hacd_mem_port.sv
`timescale 1ns/1ps
`default_nettype none

// shared memory port: engine first, then cpu reads and writes in turn
module hacd_mem_port #(
   parameter int MEM_CREDITS = hacd_cfg_pkg::DEF_MEM_CREDITS
) (
   input  logic                      clk_i,
   input  logic                      arst_n_i,
   input  hacd_bus_pkg::ctrl_state_e state_i,
   input  hacd_bus_pkg::mem_req_t    hawk_req_i,
   input  hacd_bus_pkg::cpu_rd_req_t rd_head_i,
   input  hacd_bus_pkg::cpu_wr_req_t wr_head_i,
   input  logic                      mem_credit_i,
   input  hacd_bus_pkg::mem_rsp_t    mem_rsp_i,
   output logic                      rd_pop_o,
   output logic                      wr_pop_o,
   output logic                      hawk_taken_o,
   output hacd_bus_pkg::mem_req_t    mem_req_o,
   output hacd_bus_pkg::cpu_rd_rsp_t cpu_rd_rsp_o,
   output hacd_bus_pkg::mem_rsp_t    hawk_rsp_o
);
   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   localparam int CRD_W = $clog2(MEM_CREDITS + 1);

   logic [CRD_W-1:0]  crd_q;       // memory credits in hand
   logic              has_crd;
   logic              cpu_ok;
   logic              rd_go, wr_go, any_go;
   logic              last_wr_q;   // last cpu grant was a write
   mem_req_t          sel_req;
   mem_req_t          req_q;
   logic              req_vld_q;
   logic              rsp_vld_q;
   logic [LINE_W-1:0] rsp_data_q;

   //////////////////////////////
   // selection
   assign has_crd      = (crd_q != '0);
   assign hawk_taken_o = hawk_req_i.valid && has_crd;  // engine wins
   assign cpu_ok       = has_crd && !hawk_req_i.valid && (state_i == CS_RUN);
   assign rd_go        = cpu_ok && rd_head_i.valid && (!wr_head_i.valid || last_wr_q);
   assign wr_go        = cpu_ok && wr_head_i.valid && !rd_go;
   assign any_go       = hawk_taken_o || rd_go || wr_go;
   assign rd_pop_o     = rd_go;
   assign wr_pop_o     = wr_go;

   always_comb begin
      sel_req = hawk_req_i;
      if (rd_go) begin
         sel_req = '{valid: 1'b1, write: 1'b0, src: SRC_CPU, addr: rd_head_i.addr, data: '0};
      end else if (wr_go) begin
         sel_req = '{valid: 1'b1, write: 1'b1, src: SRC_CPU,
                     addr: wr_head_i.addr, data: wr_head_i.data};
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         crd_q     <= CRD_W'(MEM_CREDITS);
         req_vld_q <= 1'b0;
         last_wr_q <= 1'b0;
         rsp_vld_q <= 1'b0;
      end else begin
         crd_q     <= crd_q - CRD_W'(any_go) + CRD_W'(mem_credit_i);
         req_vld_q <= any_go;  // issue one cycle after selection
         if (rd_go || wr_go) last_wr_q <= wr_go;
         rsp_vld_q <= mem_rsp_i.valid && (mem_rsp_i.src == SRC_CPU);
      end
   end

   always_ff @(posedge clk_i) begin
      if (any_go) req_q <= sel_req;
      if (mem_rsp_i.valid) rsp_data_q <= mem_rsp_i.data;
   end

   always_comb begin
      mem_req_o       = req_q;
      mem_req_o.valid = req_vld_q;
   end

   //////////////////////////////
   // response routing by src
   assign cpu_rd_rsp_o = '{valid: rsp_vld_q, data: rsp_data_q};  // always accepted

   always_comb begin
      hawk_rsp_o       = mem_rsp_i;  // compressor looks at it the same cycle
      hawk_rsp_o.valid = mem_rsp_i.valid && (mem_rsp_i.src == SRC_HAWK);
   end

endmodule

`default_nettype wire

// File: rtl/hacd_zero_detect.sv
`timescale 1ns/1ps
`default_nettype none

// zero-line compressor, counts the lines of a page that hold data
module hacd_zero_detect #(
   parameter int PAGE_LINES = hacd_cfg_pkg::DEF_PAGE_LINES
) (
   input  logic                     clk_i,
   input  logic                     arst_n_i,
   input  logic                     start_i,
   input  hacd_bus_pkg::mem_rsp_t   rsp_i,
   output logic                     page_done_o,
   output hacd_bus_pkg::comp_rslt_t rslt_o
);
   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   logic [CNT_W-1:0] seen_q, nz_q, nz_d;
   logic [CNT_W-1:0] nz_res_q;
   logic             incomp_q;
   logic             last_rsp, done_q;

   assign nz_d     = nz_q + CNT_W'(|rsp_i.data);  // any set bit counts
   assign last_rsp = rsp_i.valid && (seen_q == CNT_W'(PAGE_LINES - 1));

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         seen_q <= '0;
         nz_q   <= '0;
         done_q <= 1'b0;
      end else begin
         if (start_i) begin
            seen_q <= '0;
            nz_q   <= '0;
         end else if (rsp_i.valid) begin
            seen_q <= seen_q + CNT_W'(1);
            nz_q   <= nz_d;
         end
         done_q <= last_rsp;
      end
   end

   // verdict held until the next page
   always_ff @(posedge clk_i) begin
      if (last_rsp) begin
         nz_res_q <= nz_d;
         incomp_q <= (nz_d == CNT_W'(PAGE_LINES));  // nothing to squeeze out
      end
   end

   assign rslt_o      = '{valid: done_q, nonzero_lines: nz_res_q, incompressible: incomp_q};
   assign page_done_o = done_q;

endmodule

`default_nettype wire

// File: rtl/hacd_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

// control unit: table sweep, then cpu service, page reads on command
module hacd_ctrl_fsm #(
   parameter logic [hacd_cfg_pkg::ADDR_W-1:0] TBL_BASE   = hacd_cfg_pkg::DEF_TBL_BASE,
   parameter int                              TBL_LINES  = hacd_cfg_pkg::DEF_TBL_LINES,
   parameter int                              PAGE_LINES = hacd_cfg_pkg::DEF_PAGE_LINES
) (
   input  logic                               clk_i,
   input  logic                               arst_n_i,
   input  logic                               inactive_i,
   input  logic                               comp_cmd_i,
   input  logic [hacd_cfg_pkg::ADDR_W-1:0]    comp_page_i,
   input  logic [hacd_cfg_pkg::CNT_W-1:0]     line_idx_i,
   input  logic                               line_last_i,
   input  logic                               hawk_taken_i,
   input  logic                               page_done_i,
   output hacd_bus_pkg::ctrl_state_e          state_o,
   output hacd_bus_pkg::mem_req_t             hawk_req_o,
   output logic                               cntr_clr_o,
   output logic [hacd_cfg_pkg::CNT_W-1:0]     len_o,
   output logic                               ready_o,
   output logic                               comp_busy_o
);
   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   ctrl_state_e       state_q, state_d;
   logic [ADDR_W-1:0] page_q;     // first line of the page under test
   logic [ADDR_W-1:0] line_base;
   logic              rd_done_q;  // all page reads handed to the port
   logic              ready_q;
   logic              busy_q;

   //////////////////////////////
   // next state
   always_comb begin
      state_d    = state_q;
      cntr_clr_o = 1'b0;
      case (state_q)
         CS_INIT: begin
            if (inactive_i) state_d = CS_RUN;  // sw skips the sweep
            else if (hawk_taken_i && line_last_i) state_d = CS_RUN;
         end
         CS_RUN: begin
            if (comp_cmd_i) begin
               state_d    = CS_COMP;
               cntr_clr_o = 1'b1;  // restart index, also arms the compressor
            end
         end
         CS_COMP: if (page_done_i) state_d = CS_RUN;
         default: state_d = CS_INIT;
      endcase
   end

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q   <= CS_INIT;
         rd_done_q <= 1'b0;
         ready_q   <= 1'b0;
         busy_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         if (cntr_clr_o) rd_done_q <= 1'b0;
         else if (state_q == CS_COMP && hawk_taken_i && line_last_i) rd_done_q <= 1'b1;
         ready_q <= (state_q != CS_INIT) || inactive_i;  // sweep never restarts
         busy_q  <= (state_q == CS_COMP); // lags state, covers the last cpu issue
      end
   end

   always_ff @(posedge clk_i) begin
      if (cntr_clr_o) page_q <= comp_page_i;
   end

   //////////////////////////////
   // engine request
   assign line_base = (state_q == CS_INIT) ? TBL_BASE : page_q;

   always_comb begin
      hawk_req_o       = '0;
      hawk_req_o.valid = (state_q == CS_INIT && !inactive_i) ||
                         (state_q == CS_COMP && !rd_done_q);
      hawk_req_o.write = (state_q == CS_INIT);  // zero writes, page reads
      hawk_req_o.src   = SRC_HAWK;
      hawk_req_o.addr  = line_base + ADDR_W'(line_idx_i);
      hawk_req_o.data  = '0;
   end

   assign len_o       = (state_q == CS_INIT) ? CNT_W'(TBL_LINES) : CNT_W'(PAGE_LINES);
   assign state_o     = state_q;
   assign ready_o     = ready_q;
   assign comp_busy_o = busy_q;

endmodule

`default_nettype wire

// File: rtl/hacd_core.sv
`timescale 1ns/1ps
`default_nettype none

// memory-path core between cpu and memory controller
module hacd_core #(
   parameter logic [hacd_cfg_pkg::ADDR_W-1:0] TBL_BASE    = hacd_cfg_pkg::DEF_TBL_BASE,
   parameter int                              TBL_LINES   = hacd_cfg_pkg::DEF_TBL_LINES,
   parameter int                              PAGE_LINES  = hacd_cfg_pkg::DEF_PAGE_LINES,
   parameter int                              MEM_CREDITS = hacd_cfg_pkg::DEF_MEM_CREDITS,
   parameter int                              CPU_Q_DEPTH = hacd_cfg_pkg::DEF_CPU_Q_DEPTH
) (
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            inactive_i,
   input  hacd_bus_pkg::cpu_rd_req_t       cpu_rd_req_i,
   input  hacd_bus_pkg::cpu_wr_req_t       cpu_wr_req_i,
   output logic                            cpu_rd_credit_o,
   output logic                            cpu_wr_credit_o,
   output hacd_bus_pkg::cpu_rd_rsp_t       cpu_rd_rsp_o,
   output hacd_bus_pkg::mem_req_t          mem_req_o,
   input  logic                            mem_credit_i,
   input  hacd_bus_pkg::mem_rsp_t          mem_rsp_i,
   input  logic                            comp_cmd_i,
   input  logic [hacd_cfg_pkg::ADDR_W-1:0] comp_page_i,
   output logic                            ready_o,
   output logic                            comp_busy_o,
   output hacd_bus_pkg::comp_rslt_t        comp_rslt_o
);
   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   // counter must cover both the table and a page
   localparam int LINE_LIMIT = (TBL_LINES > PAGE_LINES) ? TBL_LINES : PAGE_LINES;

   ctrl_state_e      state;
   mem_req_t         hawk_req;
   mem_rsp_t         hawk_rsp;
   cpu_rd_req_t      rd_head;
   cpu_wr_req_t      wr_head;
   logic             cntr_clr, line_last, hawk_taken, page_done;
   logic             rd_pop, wr_pop;
   logic [CNT_W-1:0] line_len, line_idx;

   //////////////////////////////
   // control
   hacd_ctrl_fsm #(.TBL_BASE(TBL_BASE), .TBL_LINES(TBL_LINES), .PAGE_LINES(PAGE_LINES))
   u_ctrl_fsm (
      .clk_i, .arst_n_i, .inactive_i, .comp_cmd_i, .comp_page_i,
      .line_idx_i(line_idx), .line_last_i(line_last), .hawk_taken_i(hawk_taken),
      .page_done_i(page_done), .state_o(state), .hawk_req_o(hawk_req),
      .cntr_clr_o(cntr_clr), .len_o(line_len), .ready_o, .comp_busy_o
   );

   hacd_line_cntr #(.LIMIT(LINE_LIMIT)) u_line_cntr (
      .clk_i, .arst_n_i, .clr_i(cntr_clr), .step_i(hawk_taken),  // step per issue
      .len_i(line_len), .idx_o(line_idx), .last_o(line_last)
   );

   //////////////////////////////
   // cpu request queues
   hacd_req_queue #(.payload_t(cpu_rd_req_t), .DEPTH(CPU_Q_DEPTH)) u_rd_queue (
      .clk_i, .arst_n_i, .push_i(cpu_rd_req_i), .pop_i(rd_pop),
      .head_o(rd_head), .credit_o(cpu_rd_credit_o)
   );

   hacd_req_queue #(.payload_t(cpu_wr_req_t), .DEPTH(CPU_Q_DEPTH)) u_wr_queue (
      .clk_i, .arst_n_i, .push_i(cpu_wr_req_i), .pop_i(wr_pop),
      .head_o(wr_head), .credit_o(cpu_wr_credit_o)
   );

   // memory port and compressor
   hacd_mem_port #(.MEM_CREDITS(MEM_CREDITS)) u_mem_port (
      .clk_i, .arst_n_i, .state_i(state), .hawk_req_i(hawk_req),
      .rd_head_i(rd_head), .wr_head_i(wr_head), .mem_credit_i, .mem_rsp_i,
      .rd_pop_o(rd_pop), .wr_pop_o(wr_pop), .hawk_taken_o(hawk_taken),
      .mem_req_o, .cpu_rd_rsp_o, .hawk_rsp_o(hawk_rsp)
   );

   hacd_zero_detect #(.PAGE_LINES(PAGE_LINES)) u_zero_detect (
      .clk_i, .arst_n_i, .start_i(cntr_clr), .rsp_i(hawk_rsp),
      .page_done_o(page_done), .rslt_o(comp_rslt_o)
   );

endmodule

`default_nettype wire

// File: verification/hacd_core_props.sv
`timescale 1ns/1ps
`default_nettype none

// credit, stall and sweep rules seen at the core boundary
module hacd_core_props #(
   parameter logic [hacd_cfg_pkg::ADDR_W-1:0] TBL_BASE    = hacd_cfg_pkg::DEF_TBL_BASE,
   parameter int                              MEM_CREDITS = hacd_cfg_pkg::DEF_MEM_CREDITS,
   parameter int                              CPU_Q_DEPTH = hacd_cfg_pkg::DEF_CPU_Q_DEPTH
) (
   input logic                      clk_i,
   input logic                      arst_n_i,
   input logic                      ready_o,
   input logic                      comp_busy_o,
   input logic                      mem_credit_i,
   input logic                      cpu_rd_credit_o,
   input logic                      cpu_wr_credit_o,
   input hacd_bus_pkg::mem_req_t    mem_req_o,
   input hacd_bus_pkg::cpu_rd_req_t cpu_rd_req_i,
   input hacd_bus_pkg::cpu_wr_req_t cpu_wr_req_i,
   input hacd_bus_pkg::mem_rsp_t    mem_rsp_i,
   input hacd_bus_pkg::cpu_rd_rsp_t cpu_rd_rsp_o
);
   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   int          mem_out_q, rd_out_q, wr_out_q;  // outstanding per channel
   int          sweep_q;                        // table writes so far
   int unsigned fail_cnt = 0;

   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         mem_out_q <= 0;
         rd_out_q  <= 0;
         wr_out_q  <= 0;
         sweep_q   <= 0;
      end else begin
         mem_out_q <= mem_out_q + int'(mem_req_o.valid) - int'(mem_credit_i);
         rd_out_q  <= rd_out_q + int'(cpu_rd_req_i.valid) - int'(cpu_rd_credit_o);
         wr_out_q  <= wr_out_q + int'(cpu_wr_req_i.valid) - int'(cpu_wr_credit_o);
         if (mem_req_o.valid && !ready_o) sweep_q <= sweep_q + 1;
      end
   end

   //////////////////////////////
   // credits
   mem_crd_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_out_q <= MEM_CREDITS)
      else begin $error("memory credits overrun"); fail_cnt++; end

   // no credit comes back without a request behind it
   cpu_crd_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_out_q >= 0 && rd_out_q <= CPU_Q_DEPTH && wr_out_q >= 0 && wr_out_q <= CPU_Q_DEPTH)
      else begin $error("cpu credit count out of range"); fail_cnt++; end

   //////////////////////////////
   // engine ownership
   stall_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (comp_busy_o && mem_req_o.valid) |-> mem_req_o.src == SRC_HAWK)
      else begin $error("cpu request issued while compressing"); fail_cnt++; end

   sweep_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (!ready_o && mem_req_o.valid) |-> (mem_req_o.write && mem_req_o.src == SRC_HAWK &&
         mem_req_o.data == '0 && mem_req_o.addr == TBL_BASE + ADDR_W'(sweep_q)))
      else begin $error("bad table sweep request"); fail_cnt++; end

   // cpu read data one cycle behind memory
   rd_rsp_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      (mem_rsp_i.valid && mem_rsp_i.src == SRC_CPU) |=>
         (cpu_rd_rsp_o.valid && cpu_rd_rsp_o.data == $past(mem_rsp_i.data)))
      else begin $error("cpu read response lost or wrong"); fail_cnt++; end

endmodule

bind hacd_core hacd_core_props #(
   .TBL_BASE(TBL_BASE), .MEM_CREDITS(MEM_CREDITS), .CPU_Q_DEPTH(CPU_Q_DEPTH)
) u_props (
   .clk_i, .arst_n_i, .ready_o, .comp_busy_o, .mem_credit_i, .cpu_rd_credit_o,
   .cpu_wr_credit_o, .mem_req_o, .cpu_rd_req_i, .cpu_wr_req_i, .mem_rsp_i, .cpu_rd_rsp_o
);

`default_nettype wire

// File: verification/tb_hacd_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_hacd_core;
   import hacd_cfg_pkg::*;
   import hacd_bus_pkg::*;

   localparam logic [31:0]       SEED       = 32'h5d215e97;
   localparam int                RT_OPS     = 8;        // round trips in the first run
   localparam int                TIMEOUT    = 200;      // cycles allowed per wait
   localparam logic [ADDR_W-1:0] PAGE_BASE  = 16'h2000;
   localparam logic [ADDR_W-1:0] STALL_ADDR = 16'h3000; // read while compressing

   logic              clk_i = 1'b0;
   logic              arst_n_i, inactive_i, comp_cmd_i, mem_credit_i;
   logic              cpu_rd_credit_o, cpu_wr_credit_o, ready_o, comp_busy_o;
   logic [ADDR_W-1:0] comp_page_i;
   cpu_rd_req_t       cpu_rd_req_i;
   cpu_wr_req_t       cpu_wr_req_i;
   cpu_rd_rsp_t       cpu_rd_rsp_o;
   mem_req_t          mem_req_o;
   mem_rsp_t          mem_rsp_i;
   comp_rslt_t        comp_rslt_o;

   // memory model and scoreboard
   logic [LINE_W-1:0] mem_lines [2**ADDR_W];
   mem_req_t          pend_q [$];     // accepted and not yet retired
   int                pend_wait [$];  // cycles left for each
   logic [LINE_W-1:0] ref_lines [logic [ADDR_W-1:0]];
   logic [LINE_W-1:0] exp_rd [$];     // read data in response order
   logic [31:0]       stim_lfsr = SEED;
   logic [31:0]       mem_lfsr = {SEED[15:0], SEED[31:16]};
   int                rd_crd, wr_crd;  // cpu credits in hand
   int                sweep_wr;        // writes seen before ready
   int                busy_rsps;       // cpu responses while busy
   int                errors = 0;

   hacd_core #(
      .TBL_BASE(DEF_TBL_BASE), .TBL_LINES(DEF_TBL_LINES), .PAGE_LINES(DEF_PAGE_LINES),
      .MEM_CREDITS(DEF_MEM_CREDITS), .CPU_Q_DEPTH(DEF_CPU_Q_DEPTH)
   ) hacd_core_i (.*);

   always #50 clk_i = ~clk_i;

   //////////////////////////////
   // helpers
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {1'b0, s[31:1]} ^ (s[0] ? 32'h80200003 : 32'h0);
   endfunction

   // one lfsr step per bit taken
   function automatic logic [63:0] take_bits(inout logic [31:0] s, input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         s = lfsr_step(s);
         r = {r[62:0], s[0]};
      end
      return r;
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (exp === act) else begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic abort_run(input string what);
      $display("Timed out waiting for %s", what);
      $display("Something failed");
      $finish;
   endtask

   // every wait lands here and drops one-cycle pulses
   task automatic next_cycle();
      @(negedge clk_i);
      cpu_rd_req_i.valid = 1'b0;
      cpu_wr_req_i.valid = 1'b0;
      comp_cmd_i         = 1'b0;
   endtask

   function automatic logic drained();
      return rd_crd == DEF_CPU_Q_DEPTH && wr_crd == DEF_CPU_Q_DEPTH &&
             exp_rd.size() == 0 && pend_q.size() == 0;
   endfunction

   task automatic wait_drained(input string what);
      int n;
      for (n = 0; n < TIMEOUT && !drained(); n++) next_cycle();
      if (!drained()) abort_run(what);
   endtask

   task automatic wait_ready();
      int n;
      for (n = 0; n < TIMEOUT && !ready_o; n++) next_cycle();
      if (!ready_o) abort_run("ready after reset");
   endtask

   task automatic apply_reset(input logic inactive);
      arst_n_i   = 1'b0;
      inactive_i = inactive;
      repeat (2) next_cycle();
      rd_crd   = DEF_CPU_Q_DEPTH;  // full credits out of reset
      wr_crd   = DEF_CPU_Q_DEPTH;
      sweep_wr = 0;
      arst_n_i = 1'b1;
   endtask

   task automatic send_write(input logic [ADDR_W-1:0] addr, input logic [LINE_W-1:0] data);
      int n;
      next_cycle();
      for (n = 0; n < TIMEOUT && wr_crd == 0; n++) next_cycle();
      if (wr_crd == 0) begin
         abort_run("a write credit");
      end else begin
         cpu_wr_req_i = '{valid: 1'b1, addr: addr, data: data};
         wr_crd--;
         ref_lines[addr] = data;
      end
   endtask

   task automatic send_read(input logic [ADDR_W-1:0] addr);
      int n;
      next_cycle();
      for (n = 0; n < TIMEOUT && rd_crd == 0; n++) next_cycle();
      if (rd_crd == 0) begin
         abort_run("a read credit");
      end else begin
         cpu_rd_req_i = '{valid: 1'b1, addr: addr};
         rd_crd--;
         exp_rd.push_back(ref_lines[addr]);
      end
   endtask

   //////////////////////////////
   // memory model on the falling edge
   always @(negedge clk_i) begin
      mem_credit_i = 1'b0;
      mem_rsp_i    = '0;
      if (!arst_n_i) begin
         pend_q.delete();
         pend_wait.delete();
      end else begin
         if (cpu_rd_credit_o) rd_crd++;
         if (cpu_wr_credit_o) wr_crd++;
         if (cpu_rd_rsp_o.valid) begin
            if (comp_busy_o) busy_rsps++;
            if (exp_rd.size() == 0) begin
               $display("Read response arrived with no read outstanding");
               errors++;
            end else begin
               check_value("cpu read data", exp_rd.pop_front(), cpu_rd_rsp_o.data);
            end
         end
         if (mem_req_o.valid) begin
            if (!ready_o) sweep_wr++;
            if (mem_req_o.write) mem_lines[mem_req_o.addr] = mem_req_o.data;
            pend_q.push_back(mem_req_o);
            pend_wait.push_back(int'(take_bits(mem_lfsr, 2)));  // 0 to 3 cycles
         end
         if (pend_q.size() != 0) begin
            if (pend_wait[0] == 0) begin  // retire in order
               mem_credit_i = 1'b1;
               if (!pend_q[0].write) begin
                  mem_rsp_i = '{valid: 1'b1, src: pend_q[0].src,
                                data: mem_lines[pend_q[0].addr]};
               end
               void'(pend_q.pop_front());
               void'(pend_wait.pop_front());
            end else begin
               pend_wait[0]--;
            end
         end
      end
   end

   //////////////////////////////
   // tests
   task automatic round_trips(input int ops);
      logic [ADDR_W-1:0] addr [$];
      for (int i = 0; i < ops; i++) begin
         addr.push_back(ADDR_W'(take_bits(stim_lfsr, 12)) | 16'h4000);  // clear of table and page
         send_write(addr[i], take_bits(stim_lfsr, 64));
      end
      wait_drained("cpu writes to retire");
      for (int i = 0; i < ops; i++) send_read(addr[i]);
      wait_drained("cpu reads to return");
   endtask

   task automatic compress_page(input logic all_nz);
      int                n;
      int                nz;
      logic [LINE_W-1:0] data;
      nz = 0;
      for (int i = 0; i < DEF_PAGE_LINES; i++) begin
         data = '0;
         if (all_nz || take_bits(stim_lfsr, 1) != 0) data = take_bits(stim_lfsr, 64) | 64'h1;
         nz += int'(data != '0);
         send_write(PAGE_BASE + ADDR_W'(i), data);
      end
      send_write(STALL_ADDR, take_bits(stim_lfsr, 64));
      wait_drained("page writes to retire");
      next_cycle();
      comp_page_i = PAGE_BASE;
      comp_cmd_i  = 1'b1;
      busy_rsps   = 0;
      send_read(STALL_ADDR);  // parked in its queue until the verdict
      for (n = 0; n < TIMEOUT && !comp_rslt_o.valid; n++) next_cycle();
      if (!comp_rslt_o.valid) begin
         abort_run("the compression result");
      end else begin
         check_value("nonzero lines", nz, comp_rslt_o.nonzero_lines);
         check_value("incompressible", nz == DEF_PAGE_LINES, comp_rslt_o.incompressible);
         wait_drained("stalled read to return");
         check_value("cpu responses while busy", 0, busy_rsps);
      end
   endtask

   initial begin
      arst_n_i     = 1'b0;
      inactive_i   = 1'b0;
      comp_cmd_i   = 1'b0;
      comp_page_i  = '0;
      cpu_rd_req_i = '0;
      cpu_wr_req_i = '0;
      mem_credit_i = 1'b0;
      mem_rsp_i    = '0;
      busy_rsps    = 0;
      apply_reset(1'b0);
      round_trips(RT_OPS);  // first writes queue up behind the sweep
      wait_ready();
      check_value("table sweep writes", DEF_TBL_LINES, sweep_wr);
      compress_page(1'b0);
      compress_page(1'b1);  // every line holds data
      apply_reset(1'b1);
      wait_ready();
      check_value("sweep writes while inactive", 0, sweep_wr);
      round_trips(4);
      $display("errors: checks %0d, assertions %0d", errors, hacd_core_i.u_props.fail_cnt);
      if (errors == 0 && hacd_core_i.u_props.fail_cnt == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
rtl/hacd_cfg_pkg.sv
rtl/hacd_bus_pkg.sv
rtl/hacd_line_cntr.sv
rtl/hacd_req_queue.sv
rtl/hacd_mem_port.sv
rtl/hacd_zero_detect.sv
rtl/hacd_ctrl_fsm.sv
rtl/hacd_core.sv
verification/hacd_core_props.sv
verification/tb_hacd_core.sv

// File: Bender.yml
package:
  name: hacd_core

sources:
  - rtl/hacd_cfg_pkg.sv
  - rtl/hacd_bus_pkg.sv
  - rtl/hacd_line_cntr.sv
  - rtl/hacd_req_queue.sv
  - rtl/hacd_mem_port.sv
  - rtl/hacd_zero_detect.sv
  - rtl/hacd_ctrl_fsm.sv
  - rtl/hacd_core.sv
  - target: simulation
    files:
      - verification/hacd_core_props.sv
      - verification/tb_hacd_core.sv
